// File: logic/div241_pkg.sv
package div241_pkg;

  // constant divisor.
  localparam int divisor    = 241;

  // operand and result widths.
  localparam int dividend_w = 60;
  localparam int quot_w     = 53;
  localparam int rem_w      = 8;

  // byte slicing of the dividend.
  localparam int slice_w    = 8;
  localparam int slice_n    = 8;
  localparam int word_w     = slice_n * slice_w;

  // eight residues of at most 240 each.
  localparam int res_sum_w  = 11;

  // partial quotient above, partial residue in the low bits.
  localparam int split_w    = quot_w + rem_w;

  // dividend seen whole or by byte slice.
  typedef union packed {
    logic [word_w-1:0]               flat;
    logic [slice_n-1:0][slice_w-1:0] bytes;
  } dividend_word_u;

  // byte at slice position k, scaled by 256^k and split by the divisor.
  function automatic logic [split_w-1:0] slice_split(input logic [slice_w-1:0] b,
                                                     input int k);
    logic [word_w-1:0] scaled;
    logic [word_w-1:0] q;
    logic [word_w-1:0] r;
    scaled = word_w'(b) << (slice_w * k);
    q = scaled / word_w'(divisor);
    r = scaled % word_w'(divisor);
    return {q[quot_w-1:0], r[rem_w-1:0]};
  endfunction

endpackage

// File: logic/div241_wr_if.sv
`timescale 1ns/1ns

interface div241_wr_if;

  logic                                                    put;
  logic [div241_pkg::slice_n-1:0][div241_pkg::quot_w-1:0] part_quot;
  logic [div241_pkg::slice_n-1:0][div241_pkg::rem_w-1:0]  part_res;
  // fifo has room for one in-flight set only.
  logic                                                    nearly_full;

  modport producer (output put, output part_quot, output part_res, input nearly_full);

  modport buffer (input put, input part_quot, input part_res, output nearly_full);

endinterface

// File: logic/div241_rd_if.sv
`timescale 1ns/1ns

interface div241_rd_if;

  logic                                                    take;
  // head entry, valid while empty is low.
  logic [div241_pkg::slice_n-1:0][div241_pkg::quot_w-1:0] part_quot;
  logic [div241_pkg::slice_n-1:0][div241_pkg::rem_w-1:0]  part_res;
  logic                                                    empty;

  modport buffer (input take, output part_quot, output part_res, output empty);

  modport consumer (output take, input part_quot, input part_res, input empty);

endinterface

// File: logic/div241_slicer.sv
`timescale 1ns/1ns

module div241_slicer (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              in_valid,
  input  logic [div241_pkg::dividend_w-1:0] dividend,
  output logic                              ready,
  div241_wr_if.producer                     wr
);

  div241_pkg::dividend_word_u word;

  logic accept;

  logic [div241_pkg::slice_n-1:0][div241_pkg::quot_w-1:0] quot_next;
  logic [div241_pkg::slice_n-1:0][div241_pkg::rem_w-1:0]  res_next;

  assign ready  = !wr.nearly_full;
  assign accept = in_valid && ready;

  // zero-extend into the slice view.
  always_comb begin
    word.flat = '0;
    word.flat[div241_pkg::dividend_w-1:0] = dividend;
  end

  // one constant table per byte position.
  for (genvar k = 0; k < div241_pkg::slice_n; k++) begin : g_slice
    logic [div241_pkg::split_w-1:0] split;

    assign split = div241_pkg::slice_split(word.bytes[k], k);

    assign quot_next[k] = split[div241_pkg::split_w-1:div241_pkg::rem_w];
    assign res_next[k]  = split[div241_pkg::rem_w-1:0];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr.put <= 1'b0;
    end else begin
      wr.put <= accept;
    end
  end

  // partial set, written to the fifo on the next edge.
  always_ff @(posedge clk) begin
    if (accept) begin
      wr.part_quot <= quot_next;
      wr.part_res  <= res_next;
    end
  end

endmodule

// File: logic/div241_fifo.sv
`timescale 1ns/1ns

module div241_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic        clk,
  input  logic        rst_n,
  div241_wr_if.buffer wr,
  div241_rd_if.buffer rd
);

  localparam int ptr_w = $clog2(FIFO_DEPTH);
  localparam int cnt_w = $clog2(FIFO_DEPTH + 1);

  logic [div241_pkg::slice_n-1:0][div241_pkg::quot_w-1:0] quot_mem [FIFO_DEPTH];
  logic [div241_pkg::slice_n-1:0][div241_pkg::rem_w-1:0]  res_mem  [FIFO_DEPTH];

  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;

  logic full;
  logic push;
  logic pop;

  // wrap for depths that are not a power of two.
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
    if (p == ptr_w'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign full = (count == cnt_w'(FIFO_DEPTH));
  assign push = wr.put && !full;
  assign pop  = rd.take && (count != '0);

  assign rd.empty       = (count == '0);
  assign wr.nearly_full = (count >= cnt_w'(FIFO_DEPTH - 1));

  assign rd.part_quot = quot_mem[rd_ptr];
  assign rd.part_res  = res_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // put and take together leave the count alone.
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      quot_mem[wr_ptr] <= wr.part_quot;
      res_mem[wr_ptr]  <= wr.part_res;
    end
  end

endmodule

// File: logic/div241_accumulator.sv
`timescale 1ns/1ns

module div241_accumulator (
  input  logic                          clk,
  input  logic                          rst_n,
  div241_rd_if.consumer                 rd,
  output logic [div241_pkg::quot_w-1:0] quotient,
  output logic [div241_pkg::rem_w-1:0]  remainder,
  output logic                          out_valid
);

  localparam int idx_w = $clog2(div241_pkg::slice_n);

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_sum  = 2'd1;
  localparam logic [1:0] st_fix  = 2'd2;

  logic [1:0]       state;
  logic [idx_w-1:0] slice_cnt;
  logic             fold;

  logic [div241_pkg::slice_n-1:0][div241_pkg::quot_w-1:0] ent_quot;
  logic [div241_pkg::slice_n-1:0][div241_pkg::rem_w-1:0]  ent_res;

  logic [div241_pkg::quot_w-1:0]    acc_q;
  logic [div241_pkg::res_sum_w-1:0] acc_r;

  logic [idx_w-1:0] corr;
  logic [idx_w-1:0] corr_next;

  assign rd.take = (state == st_idle) && !rd.empty;

  // how many multiples of the divisor fit in the residue sum.
  always_comb begin
    corr_next = '0;
    for (int m = 1; m < div241_pkg::slice_n; m++) begin
      if (acc_r >= div241_pkg::res_sum_w'(m * div241_pkg::divisor)) begin
        corr_next = idx_w'(m);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= st_idle;
      slice_cnt <= '0;
      fold      <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      fold      <= 1'b0;
      out_valid <= fold;
      case (state)
        st_idle: begin
          if (rd.take) begin
            state     <= st_sum;
            slice_cnt <= '0;
          end
        end
        st_sum: begin
          slice_cnt <= slice_cnt + 1'b1;
          if (slice_cnt == idx_w'(div241_pkg::slice_n - 1)) begin
            state <= st_fix;
          end
        end
        st_fix: begin
          fold  <= 1'b1;
          state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // next pop may land on the fold edge, old sums are read there.
  always_ff @(posedge clk) begin
    if (rd.take) begin
      ent_quot <= rd.part_quot;
      ent_res  <= rd.part_res;
      acc_q    <= '0;
      acc_r    <= '0;
    end else if (state == st_sum) begin
      acc_q <= acc_q + ent_quot[slice_cnt];
      acc_r <= acc_r + div241_pkg::res_sum_w'(ent_res[slice_cnt]);
    end
    if (state == st_fix) begin
      corr <= corr_next;
    end
    if (fold) begin
      quotient  <= acc_q + div241_pkg::quot_w'(corr);
      remainder <= div241_pkg::rem_w'(acc_r - div241_pkg::res_sum_w'(corr) *
                                      div241_pkg::res_sum_w'(div241_pkg::divisor));
    end
  end

endmodule

// File: logic/div241_top.sv
`timescale 1ns/1ns

module div241_top #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              in_valid,
  input  logic [div241_pkg::dividend_w-1:0] dividend,
  output logic                              ready,
  output logic [div241_pkg::quot_w-1:0]     quotient,
  output logic [div241_pkg::rem_w-1:0]      remainder,
  output logic                              out_valid
);

  div241_wr_if wr_if0 ();
  div241_rd_if rd_if0 ();

  // partial tables, one set per dividend.
  div241_slicer slicer0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .dividend (dividend),
    .ready    (ready),
    .wr       (wr_if0.producer)
  );

  div241_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) fifo0 (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (wr_if0.buffer),
    .rd    (rd_if0.buffer)
  );

  // one result every ten cycles.
  div241_accumulator acc0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd        (rd_if0.consumer),
    .quotient  (quotient),
    .remainder (remainder),
    .out_valid (out_valid)
  );

endmodule

// File: testbench/div241_assert.sv
`timescale 1ns/1ns

module div241_assert (
  input logic                         clk,
  input logic                         rst_n,
  input logic                         ready,
  input logic                         out_valid,
  input logic [div241_pkg::rem_w-1:0] remainder,
  input logic                         put,
  input logic                         fifo_full
);

  // results are single-cycle pulses.
  a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |=> !out_valid)
    else $error("out_valid stayed high for two cycles");

  a_rem_range: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> (remainder < div241_pkg::rem_w'(div241_pkg::divisor)))
    else $error("remainder not below the divisor");

  // held reset, sampled after the first reset edge.
  a_reset_levels: assert property (@(posedge clk)
    (!rst_n && $past(!rst_n)) |-> (!out_valid && ready))
    else $error("out_valid or ready wrong during reset");

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    put |-> !fifo_full)
    else $error("slicer put a set into a full fifo");

endmodule

bind div241_top div241_assert assert0 (
  .clk       (clk),
  .rst_n     (rst_n),
  .ready     (ready),
  .out_valid (out_valid),
  .remainder (remainder),
  .put       (wr_if0.put),
  .fifo_full (fifo0.full)
);

// File: testbench/tb_div241.sv
`timescale 1ns/1ns

module tb_div241;

  localparam int fifo_depth    = 4;
  localparam int reset_cycles  = 8;
  localparam int quiet_cycles  = 16;
  localparam int result_cycles = 10;
  localparam int pipe_latency  = 12;
  localparam int drain_slack   = 20;
  localparam int edge_n        = 15;
  localparam int byte_pick_n   = 5;
  localparam int burst_n       = 40;
  localparam int item_n = 1 + edge_n + div241_pkg::slice_n * byte_pick_n + burst_n;
  localparam int watchdog_cycles = reset_cycles + quiet_cycles + item_n * result_cycles +
                                   pipe_latency + 200;

  localparam logic [div241_pkg::dividend_w-1:0] edge_vals [edge_n] = '{
    60'd0,
    60'd240,
    60'd241,
    60'd242,
    60'd482,
    60'd58081,
    60'd241000723,
    (60'hFFF_FFFF_FFFF_FFFF / 60'd241) * 60'd241,
    60'hFFF_FFFF_FFFF_FFFF,
    60'hFFF_FFFF_FFFF_FFFE,
    60'h0FF_FFFF_FFFF_FFFF,
    60'h0FF_FFFF_FFFF,
    60'hFFFF,
    60'hFF,
    // every residue at 240 except the top nibble.
    60'hFF0_E210_F0E2_10F0
  };

  // last pick per slice is a random nonzero byte.
  localparam logic [7:0] byte_picks [byte_pick_n - 1] = '{8'h01, 8'h0F, 8'hA5, 8'hFF};

  logic                              clk;
  logic                              rst_n;
  logic                              in_valid;
  logic [div241_pkg::dividend_w-1:0] dividend;
  logic                              ready;
  logic [div241_pkg::quot_w-1:0]     quotient;
  logic [div241_pkg::rem_w-1:0]      remainder;
  logic                              out_valid;

  logic [div241_pkg::dividend_w-1:0] ref_q [$];

  logic took_last;
  logic ready_low_seen;

  div241_top #(
    .FIFO_DEPTH (fifo_depth)
  ) dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .dividend  (dividend),
    .ready     (ready),
    .quotient  (quotient),
    .remainder (remainder),
    .out_valid (out_valid)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_quotient(input logic [div241_pkg::quot_w-1:0] exp,
                                input logic [div241_pkg::quot_w-1:0] act);
    if (act !== exp) begin
      stop_with_failure($sformatf("Fail quotient: expected %0h, got %0h", exp, act));
    end
  endtask

  task automatic check_remainder(input logic [div241_pkg::rem_w-1:0] exp,
                                 input logic [div241_pkg::rem_w-1:0] act);
    if (act !== exp) begin
      stop_with_failure($sformatf("Fail remainder: expected %0h, got %0h", exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_with_failure($sformatf("Fail %s: expected %0h, got %0h", name, exp, act));
    end
  endtask

  task automatic check_latency(input int exp, input int act);
    if (act != exp) begin
      stop_with_failure($sformatf("Fail latency: expected %0h, got %0h", exp, act));
    end
  endtask

  // strobe only if no accept landed on the edge before, so ready holds.
  task automatic send_dividend(input logic [div241_pkg::dividend_w-1:0] d);
    logic room;
    room = 1'b0;
    while (!room) begin
      @(negedge clk);
      if (!ready) begin
        ready_low_seen = 1'b1;
      end
      room = ready && !took_last;
      took_last = in_valid && ready;
      @(posedge clk);
      if (room) begin
        in_valid <= 1'b1;
        dividend <= d;
      end else begin
        in_valid <= 1'b0;
      end
    end
  endtask

  task automatic idle_input();
    @(negedge clk);
    took_last = in_valid && ready;
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    int limit;
    limit = ref_q.size() * result_cycles + pipe_latency + drain_slack;
    for (int i = 0; i < limit && ref_q.size() != 0; i++) begin
      @(posedge clk);
    end
  endtask

  task automatic test_reset_state();
    repeat (quiet_cycles) begin
      @(negedge clk);
      check_flag("ready", 1'b1, ready);
      check_flag("out_valid", 1'b0, out_valid);
    end
  endtask

  task automatic test_single_latency();
    int lat;
    wait_drain();
    if (ref_q.size() != 0) begin
      stop_with_failure("pipeline did not drain before the latency test");
    end
    send_dividend(60'h123_4567_89AB_CDEF);
    // returns on the edge that samples the strobe.
    idle_input();
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
      @(negedge clk);
    end while (!out_valid && lat < pipe_latency + drain_slack);
    check_flag("out_valid", 1'b1, out_valid);
    check_latency(pipe_latency, lat);
  endtask

  task automatic test_edges();
    for (int i = 0; i < edge_n; i++) begin
      send_dividend(edge_vals[i]);
    end
    idle_input();
    wait_drain();
  endtask

  task automatic test_single_bytes();
    logic [7:0] b;
    for (int k = 0; k < div241_pkg::slice_n; k++) begin
      for (int v = 0; v < byte_pick_n; v++) begin
        if (v < byte_pick_n - 1) begin
          b = byte_picks[v];
        end else if (k == div241_pkg::slice_n - 1) begin
          b = 8'($urandom_range(15, 1));
        end else begin
          b = 8'($urandom_range(255, 1));
        end
        // top slice holds bits 56 to 59 only.
        if (k == div241_pkg::slice_n - 1) begin
          b = b & 8'h0F;
        end
        send_dividend(div241_pkg::dividend_w'(64'(b) << (8 * k)));
      end
    end
    idle_input();
    wait_drain();
  endtask

  task automatic test_burst();
    logic [63:0] r;
    ready_low_seen = 1'b0;
    repeat (burst_n) begin
      r = {$urandom(), $urandom()};
      send_dividend(div241_pkg::dividend_w'(r));
    end
    idle_input();
    if (!ready_low_seen) begin
      stop_with_failure("ready never dropped during the burst");
    end
    wait_drain();
  endtask

  // reference model and result compare.
  always @(negedge clk) begin : watch_results
    logic [63:0] wide;
    if (rst_n) begin
      if (out_valid) begin
        if (ref_q.size() == 0) begin
          stop_with_failure("out_valid rose with no dividend outstanding");
        end else begin
          wide = 64'(ref_q.pop_front());
          check_quotient(div241_pkg::quot_w'(wide / 64'(div241_pkg::divisor)), quotient);
          check_remainder(div241_pkg::rem_w'(wide % 64'(div241_pkg::divisor)), remainder);
        end
      end
      if (in_valid) begin
        if (!ready) begin
          stop_with_failure("a dividend was strobed while ready was low");
        end else begin
          ref_q.push_back(dividend);
        end
      end
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    stop_with_failure("watchdog expired before all results arrived");
  end

  initial begin
    rst_n          = 1'b0;
    in_valid       = 1'b0;
    dividend       = '0;
    took_last      = 1'b0;
    ready_low_seen = 1'b0;
    void'($urandom(32'head0930c));
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;

    test_reset_state();
    test_single_latency();
    test_edges();
    test_single_bytes();
    test_burst();
    wait_drain();

    if (ref_q.size() == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      stop_with_failure("results still outstanding at the end of the run");
    end
  end

endmodule

// File: compile.f
logic/div241_pkg.sv
logic/div241_wr_if.sv
logic/div241_rd_if.sv
logic/div241_slicer.sv
logic/div241_fifo.sv
logic/div241_accumulator.sv
logic/div241_top.sv
testbench/div241_assert.sv
testbench/tb_div241.sv

// File: Makefile
# Verilator build and run for the divide-by-241 pipeline.

VERILATOR ?= verilator
TOP       ?= tb_div241
RTL_TOP   ?= div241_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# the simulator exits non-zero on $fatal or a failed assertion.
run: build
	./$(SIM)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
